// ==== source/mhq_config.svh ====
/* Configuration macros for the miss handling queue
   Line size, queue depth, address and data widths */

`ifndef MHQ_CONFIG_SVH
`define MHQ_CONFIG_SVH

// Bytes in a cache line
`define DC_LINE_SIZE 16

// Bits of byte offset inside a line
`define DC_OFFSET_WIDTH 4

// Byte address width
`define ADDR_WIDTH 32

// Store word width, four bytes
`define DATA_WIDTH 32

// Number of queue entries and width of an entry index
`define MHQ_DEPTH 4
`define MHQ_TAG_WIDTH 2

`endif

// ==== source/cache_types_pkg.sv ====
/* Cache-level vector types: addresses, words, lines, offsets, byte masks */

`default_nettype none

`include "mhq_config.svh"

package cache_types_pkg;

    // Full byte address
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // Line address with the offset bits dropped
    typedef logic [`ADDR_WIDTH-`DC_OFFSET_WIDTH-1:0] line_addr_t;

    // Byte offset inside a line
    typedef logic [`DC_OFFSET_WIDTH-1:0] offset_t;

    // Store word and its byte enables
    typedef logic [`DATA_WIDTH-1:0] data_t;
    typedef logic [`DATA_WIDTH/8-1:0] byte_select_t;

    // Whole line of data
    typedef logic [`DC_LINE_SIZE*8-1:0] cacheline_t;

    // One flag per line byte, set once a store wrote it
    typedef logic [`DC_LINE_SIZE-1:0] line_mask_t;

endpackage

`default_nettype wire

// ==== source/mhq_types_pkg.sv ====
/* Queue-level types: entry tags, wrap pointers, one-hot entry masks */

`default_nettype none

`include "mhq_config.svh"

package mhq_types_pkg;

    // Entry index
    typedef logic [`MHQ_TAG_WIDTH-1:0] mhq_tag_t;

    // Head or tail pointer, top bit flips on every wrap
    typedef logic [`MHQ_TAG_WIDTH:0] mhq_tagp_t;

    // One bit per entry
    typedef logic [`MHQ_DEPTH-1:0] mhq_tag_select_t;

endpackage

`default_nettype wire

// ==== source/mhq_lu.sv ====
/* MHQ lookup stage: matches a miss against queued lines
   and picks the entry it allocates or merges into */

`default_nettype none

`include "mhq_config.svh"

module mhq_lu (
    input  wire logic                                          clk,
    input  wire logic                                          n_rst,

    // Incoming miss
    input  wire logic                                          i_req_en,
    input  wire logic                                          i_req_we,
    input  wire cache_types_pkg::addr_t                        i_req_addr,
    input  wire cache_types_pkg::data_t                        i_req_wr_data,
    input  wire cache_types_pkg::byte_select_t                 i_req_byte_select,

    // Queue state from the execute stage
    input  wire mhq_types_pkg::mhq_tag_select_t                i_mhq_valid,
    input  wire cache_types_pkg::line_addr_t [`MHQ_DEPTH-1:0]  i_mhq_addr,
    input  wire mhq_types_pkg::mhq_tag_t                       i_mhq_tail,
    input  wire logic                                          i_mhq_full,

    // Held miss towards the execute stage
    output logic                                               o_lu_en,
    output logic                                               o_lu_we,
    output logic                                               o_lu_match,
    output mhq_types_pkg::mhq_tag_select_t                     o_lu_tag_select,
    output cache_types_pkg::line_addr_t                        o_lu_addr,
    output cache_types_pkg::offset_t                           o_lu_offset,
    output cache_types_pkg::data_t                             o_lu_wr_data,
    output cache_types_pkg::byte_select_t                      o_lu_byte_select,
    output logic                                               o_req_replay
);

    import cache_types_pkg::*;
    import mhq_types_pkg::*;

    line_addr_t      req_line;
    offset_t         req_offset;
    mhq_tag_select_t entry_hit;
    logic            held_hit;
    logic            held_alloc;
    logic            line_hit;
    mhq_tag_t        alloc_tag;
    logic            no_room;
    mhq_tag_select_t tag_select;

    assign req_line   = i_req_addr[`ADDR_WIDTH-1:`DC_OFFSET_WIDTH];
    assign req_offset = i_req_addr[`DC_OFFSET_WIDTH-1:0];

    // Compare against every valid queued line
    always_comb begin
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            entry_hit[i] = i_mhq_valid[i] && (i_mhq_addr[i] == req_line);
        end
    end

    // The held miss is written at the next edge, so it is not in the queue yet
    assign held_hit   = o_lu_en && (o_lu_addr == req_line);
    assign held_alloc = o_lu_en && !o_lu_match;
    assign line_hit   = held_hit || (|entry_hit);

    // Skip the slot the held miss is about to take
    assign alloc_tag  = held_alloc ? mhq_tag_t'(i_mhq_tail + 1'b1) : i_mhq_tail;

    // Full covers the settled queue, the valid check covers the held allocation
    assign no_room    = i_mhq_full || i_mhq_valid[alloc_tag];

    always_comb begin
        if (held_hit)
            tag_select = o_lu_tag_select;
        else if (|entry_hit)
            tag_select = entry_hit;
        else
            tag_select = mhq_tag_select_t'(1) << alloc_tag;
    end

    // New line with no room left is replayed instead of enqueued
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_lu_en      <= 1'b0;
            o_req_replay <= 1'b0;
        end else begin
            o_lu_en      <= i_req_en && (line_hit || !no_room);
            o_req_replay <= i_req_en && !line_hit && no_room;
        end
    end

    always_ff @(posedge clk) begin
        o_lu_we          <= i_req_we;
        o_lu_match       <= line_hit;
        o_lu_tag_select  <= tag_select;
        o_lu_addr        <= req_line;
        o_lu_offset      <= req_offset;
        o_lu_wr_data     <= i_req_wr_data;
        o_lu_byte_select <= i_req_byte_select;
    end

endmodule

`default_nettype wire

// ==== source/mhq_ex.sv ====
/* MHQ execute stage with entry storage, store merging, head and tail,
   CCU request from the head and merged fill output */

`default_nettype none

`include "mhq_config.svh"

module mhq_ex (
    input  wire logic                                      clk,
    input  wire logic                                      n_rst,

    // Held miss from the lookup stage
    input  wire logic                                      i_lu_en,
    input  wire logic                                      i_lu_we,
    input  wire logic                                      i_lu_match,
    input  wire mhq_types_pkg::mhq_tag_select_t            i_lu_tag_select,
    input  wire cache_types_pkg::line_addr_t               i_lu_addr,
    input  wire cache_types_pkg::offset_t                  i_lu_offset,
    input  wire cache_types_pkg::data_t                    i_lu_wr_data,
    input  wire cache_types_pkg::byte_select_t             i_lu_byte_select,

    // Queue state for the lookup stage
    output mhq_types_pkg::mhq_tag_select_t                 o_mhq_valid,
    output cache_types_pkg::line_addr_t [`MHQ_DEPTH-1:0]   o_mhq_addr,
    output mhq_types_pkg::mhq_tag_t                        o_mhq_tail,
    output logic                                           o_mhq_full,

    // CCU request and response
    input  wire logic                                      i_ccu_done,
    input  wire cache_types_pkg::cacheline_t               i_ccu_data,
    output logic                                           o_ccu_en,
    output cache_types_pkg::addr_t                         o_ccu_addr,

    // Fill towards the cache
    output logic                                           o_fill_en,
    output mhq_types_pkg::mhq_tag_t                        o_fill_tag,
    output logic                                           o_fill_dirty,
    output cache_types_pkg::addr_t                         o_fill_addr,
    output cache_types_pkg::cacheline_t                    o_fill_data
);

    import cache_types_pkg::*;
    import mhq_types_pkg::*;

    localparam int WORD_BYTES = `DATA_WIDTH / 8;

    // Entry storage
    mhq_tag_select_t             mhq_valid;
    mhq_tag_select_t             mhq_dirty;
    line_addr_t [`MHQ_DEPTH-1:0] mhq_line;
    cacheline_t                  mhq_data [`MHQ_DEPTH];
    line_mask_t                  mhq_mask [`MHQ_DEPTH];

    mhq_tagp_t       mhq_head;
    mhq_tagp_t       mhq_tail;
    mhq_tagp_t       head_next;
    mhq_tagp_t       tail_next;
    mhq_tag_t        head_tag;
    logic            full_next;
    mhq_tag_select_t valid_next;

    logic            ex_alloc;
    logic            base_dirty;
    cacheline_t      base_data;
    line_mask_t      base_mask;
    logic            ex_dirty;
    cacheline_t      ex_data;
    line_mask_t      ex_mask;

    cacheline_t      fill_data;

    assign ex_alloc  = i_lu_en && !i_lu_match;
    assign head_tag  = mhq_head[`MHQ_TAG_WIDTH-1:0];
    assign head_next = i_ccu_done ? mhq_tagp_t'(mhq_head + 1'b1) : mhq_head;
    assign tail_next = ex_alloc ? mhq_tagp_t'(mhq_tail + 1'b1) : mhq_tail;

    // Same index with opposite wrap bits means every slot is taken
    assign full_next = (tail_next == {~head_next[`MHQ_TAG_WIDTH],
                                      head_next[`MHQ_TAG_WIDTH-1:0]});

    // A merge starts from the stored entry and a new line from zero
    always_comb begin
        base_dirty = 1'b0;
        base_data  = '0;
        base_mask  = '0;
        if (i_lu_match) begin
            for (int i = 0; i < `MHQ_DEPTH; i++) begin
                if (i_lu_tag_select[i]) begin
                    base_dirty = mhq_dirty[i];
                    base_data  = mhq_data[i];
                    base_mask  = mhq_mask[i];
                end
            end
        end
    end

    // Lay the enabled store bytes over the word at the offset
    always_comb begin
        ex_dirty = base_dirty || i_lu_we;
        ex_data  = base_data;
        ex_mask  = base_mask;
        for (int b = 0; b < `DC_LINE_SIZE; b++) begin
            if (i_lu_we && (b / WORD_BYTES == int'(i_lu_offset) / WORD_BYTES)
                    && i_lu_byte_select[b % WORD_BYTES]) begin
                ex_data[b*8 +: 8] = i_lu_wr_data[(b % WORD_BYTES)*8 +: 8];
                ex_mask[b]        = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            valid_next[i] = mhq_valid[i];
            if (i_lu_en && i_lu_tag_select[i])
                valid_next[i] = 1'b1;
            // Head entry is freed when its line comes back
            if (i_ccu_done && (mhq_tag_t'(i) == head_tag))
                valid_next[i] = 1'b0;
        end
    end

    // Stored bytes win over the line from memory
    always_comb begin
        for (int b = 0; b < `DC_LINE_SIZE; b++) begin
            fill_data[b*8 +: 8] = mhq_mask[head_tag][b] ? mhq_data[head_tag][b*8 +: 8]
                                                        : i_ccu_data[b*8 +: 8];
        end
    end

    assign o_ccu_en    = mhq_valid[head_tag];
    assign o_ccu_addr  = {mhq_line[head_tag], {`DC_OFFSET_WIDTH{1'b0}}};

    assign o_mhq_valid = mhq_valid;
    assign o_mhq_addr  = mhq_line;
    assign o_mhq_tail  = mhq_tail[`MHQ_TAG_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            mhq_valid  <= '0;
            mhq_head   <= '0;
            mhq_tail   <= '0;
            o_mhq_full <= 1'b0;
            o_fill_en  <= 1'b0;
        end else begin
            mhq_valid  <= valid_next;
            mhq_head   <= head_next;
            mhq_tail   <= tail_next;
            o_mhq_full <= full_next;
            o_fill_en  <= i_ccu_done;
        end
    end

    // Allocate or merge into the selected entry
    always_ff @(posedge clk) begin
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            if (i_lu_en && i_lu_tag_select[i]) begin
                mhq_dirty[i] <= ex_dirty;
                mhq_line[i]  <= i_lu_addr;
                mhq_data[i]  <= ex_data;
                mhq_mask[i]  <= ex_mask;
            end
        end
    end

    // Fill is registered one cycle behind the CCU completion
    always_ff @(posedge clk) begin
        o_fill_tag   <= head_tag;
        o_fill_dirty <= mhq_dirty[head_tag];
        o_fill_addr  <= o_ccu_addr;
        o_fill_data  <= fill_data;
    end

endmodule

`default_nettype wire

// ==== source/mhq_top.sv ====
/* MHQ top level: lookup stage feeding the execute stage */

`default_nettype none

`include "mhq_config.svh"

module mhq_top (
    input  wire logic                           clk,
    input  wire logic                           n_rst,

    // Miss requests
    input  wire logic                           i_req_en,
    input  wire logic                           i_req_we,
    input  wire cache_types_pkg::addr_t         i_req_addr,
    input  wire cache_types_pkg::data_t         i_req_wr_data,
    input  wire cache_types_pkg::byte_select_t  i_req_byte_select,
    output logic                                o_req_replay,
    output logic                                o_mhq_full,

    // CCU
    input  wire logic                           i_ccu_done,
    input  wire cache_types_pkg::cacheline_t    i_ccu_data,
    output logic                                o_ccu_en,
    output cache_types_pkg::addr_t              o_ccu_addr,

    // Fill
    output logic                                o_fill_en,
    output mhq_types_pkg::mhq_tag_t             o_fill_tag,
    output logic                                o_fill_dirty,
    output cache_types_pkg::addr_t              o_fill_addr,
    output cache_types_pkg::cacheline_t         o_fill_data
);

    import cache_types_pkg::*;
    import mhq_types_pkg::*;

    // Lookup to execute
    logic            lu_en;
    logic            lu_we;
    logic            lu_match;
    mhq_tag_select_t lu_tag_select;
    line_addr_t      lu_addr;
    offset_t         lu_offset;
    data_t           lu_wr_data;
    byte_select_t    lu_byte_select;

    // Execute back to lookup
    mhq_tag_select_t             mhq_valid;
    line_addr_t [`MHQ_DEPTH-1:0] mhq_addr;
    mhq_tag_t                    mhq_tail;
    logic                        mhq_full;

    assign o_mhq_full = mhq_full;

    mhq_lu u_lu (
        .clk               (clk),
        .n_rst             (n_rst),
        .i_req_en          (i_req_en),
        .i_req_we          (i_req_we),
        .i_req_addr        (i_req_addr),
        .i_req_wr_data     (i_req_wr_data),
        .i_req_byte_select (i_req_byte_select),
        .i_mhq_valid       (mhq_valid),
        .i_mhq_addr        (mhq_addr),
        .i_mhq_tail        (mhq_tail),
        .i_mhq_full        (mhq_full),
        .o_lu_en           (lu_en),
        .o_lu_we           (lu_we),
        .o_lu_match        (lu_match),
        .o_lu_tag_select   (lu_tag_select),
        .o_lu_addr         (lu_addr),
        .o_lu_offset       (lu_offset),
        .o_lu_wr_data      (lu_wr_data),
        .o_lu_byte_select  (lu_byte_select),
        .o_req_replay      (o_req_replay)
    );

    mhq_ex u_ex (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_lu_en          (lu_en),
        .i_lu_we          (lu_we),
        .i_lu_match       (lu_match),
        .i_lu_tag_select  (lu_tag_select),
        .i_lu_addr        (lu_addr),
        .i_lu_offset      (lu_offset),
        .i_lu_wr_data     (lu_wr_data),
        .i_lu_byte_select (lu_byte_select),
        .o_mhq_valid      (mhq_valid),
        .o_mhq_addr       (mhq_addr),
        .o_mhq_tail       (mhq_tail),
        .o_mhq_full       (mhq_full),
        .i_ccu_done       (i_ccu_done),
        .i_ccu_data       (i_ccu_data),
        .o_ccu_en         (o_ccu_en),
        .o_ccu_addr       (o_ccu_addr),
        .o_fill_en        (o_fill_en),
        .o_fill_tag       (o_fill_tag),
        .o_fill_dirty     (o_fill_dirty),
        .o_fill_addr      (o_fill_addr),
        .o_fill_data      (o_fill_data)
    );

endmodule

`default_nettype wire

// ==== tb/mhq_tb_table.svh ====
/* Stimulus table of misses, grouped into tests by the last-row flag */

`ifndef MHQ_TB_TABLE_SVH
`define MHQ_TB_TABLE_SVH

// Columns: store, byte address, store data, byte enables, idle gap, replay expected, last row
task automatic load_table();
    // Load miss
    add_row(1'b0, 32'h0000_1040, 32'h0000_0000, 4'b0000, 2, 1'b0, 1'b1);
    // Store miss
    add_row(1'b1, 32'h0000_2084, 32'ha1b2_c3d4, 4'b0110, 2, 1'b0, 1'b1);
    // Merging, back-to-back stores to one line then a second line
    add_row(1'b1, 32'h3000_0100, 32'h1122_3344, 4'b1111, 0, 1'b0, 1'b0);
    add_row(1'b1, 32'h3000_0104, 32'h5566_7788, 4'b0011, 0, 1'b0, 1'b0);
    add_row(1'b1, 32'h3000_0100, 32'h99aa_bbcc, 4'b1000, 1, 1'b0, 1'b0);
    add_row(1'b0, 32'h3000_0208, 32'h0000_0000, 4'b0000, 0, 1'b0, 1'b0);
    add_row(1'b1, 32'h3000_020c, 32'hdead_beef, 4'b0101, 2, 1'b0, 1'b1);
    // Full queue, a new line is replayed, a queued line still merges
    add_row(1'b0, 32'h4000_0000, 32'h0000_0000, 4'b0000, 0, 1'b0, 1'b0);
    add_row(1'b1, 32'h4000_0010, 32'h0bad_f00d, 4'b1111, 0, 1'b0, 1'b0);
    add_row(1'b0, 32'h4000_0020, 32'h0000_0000, 4'b0000, 1, 1'b0, 1'b0);
    add_row(1'b1, 32'h4000_0030, 32'hcafe_f00d, 4'b1100, 2, 1'b0, 1'b0);
    add_row(1'b1, 32'h4000_0040, 32'h1234_5678, 4'b1111, 1, 1'b1, 1'b0);
    add_row(1'b1, 32'h4000_0018, 32'hfeed_face, 4'b0001, 2, 1'b0, 1'b1);
    // Order and tags with the CCU running freely
    add_row(1'b0, 32'h5000_0000, 32'h0000_0000, 4'b0000, 1, 1'b0, 1'b0);
    add_row(1'b1, 32'h5000_1004, 32'h0102_0304, 4'b0001, 0, 1'b0, 1'b0);
    add_row(1'b0, 32'h5000_2008, 32'h0000_0000, 4'b0000, 3, 1'b0, 1'b0);
    add_row(1'b1, 32'h5000_300c, 32'ha5a5_a5a5, 4'b1111, 2, 1'b0, 1'b1);
endtask

`endif

// ==== tb/mhq_tb.sv ====
/* MHQ testbench: clock, reset, table loop, CCU model, reference queue,
   fill checks and timeout */

`default_nettype none

`include "mhq_config.svh"

module mhq_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import cache_types_pkg::*;

    typedef struct packed {
        logic         we;
        addr_t        addr;
        data_t        data;
        byte_select_t be;
        logic [3:0]   gap;
        logic         replay;
        logic         last;
    } row_t;

    logic clk;
    logic n_rst;
    logic i_req_en;
    logic i_req_we;
    addr_t i_req_addr;
    data_t i_req_wr_data;
    byte_select_t i_req_byte_select;
    logic o_req_replay;
    logic o_mhq_full;
    logic i_ccu_done;
    cacheline_t i_ccu_data;
    logic o_ccu_en;
    addr_t o_ccu_addr;
    logic o_fill_en;
    logic [`MHQ_TAG_WIDTH-1:0] o_fill_tag;
    logic o_fill_dirty;
    addr_t o_fill_addr;
    cacheline_t o_fill_data;

    row_t rows[$];
    string test_names[5] = '{"load miss", "store miss", "merging", "full and replay",
                             "order and tags"};
    bit test_hold[5] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0};

    // Reference queue in first-miss order
    line_addr_t ref_line[$];
    cacheline_t ref_data[$];
    line_mask_t ref_mask[$];
    logic       ref_dirty[$];

    logic [31:0] rng;
    logic ccu_hold;
    int ccu_wait;
    addr_t ccu_req_addr;
    logic [`MHQ_TAG_WIDTH-1:0] fill_tag;
    int errors, pass_count, fail_count, err_start;
    int ccu_reqs, reqs_start, lines_pushed, lines_start;
    int cycles, cycle_limit;

    mhq_top mhq_top_i (.*);

    always #5 clk = ~clk;

    // Run limit scales with the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Memory line as the CCU returns it
    function automatic cacheline_t ccu_line(input line_addr_t la);
        cacheline_t l;
        logic [31:0] w;
        w = xorshift32(32'(la));
        for (int k = 0; k < `DC_LINE_SIZE / 4; k++) begin
            l[k*32 +: 32] = w;
            w = xorshift32(w);
        end
        return l;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] got);
        $display("error: %s expected 0x%0h got 0x%0h", name, exp, got);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("failure: %s", what);
        errors++;
    endtask

    task automatic add_row(input logic we, input addr_t addr, input data_t data,
                           input byte_select_t be, input int gap, input logic replay,
                           input logic last);
        rows.push_back('{we, addr, data, be, gap[3:0], replay, last});
    endtask

    `include "mhq_tb_table.svh"

    // New line goes to the back, a known line takes the store bytes
    task automatic enqueue_ref(input row_t r);
        line_addr_t la;
        cacheline_t d;
        line_mask_t m;
        int idx;
        int base;
        la = r.addr[`ADDR_WIDTH-1:`DC_OFFSET_WIDTH];
        idx = -1;
        foreach (ref_line[i])
            if (ref_line[i] == la)
                idx = i;
        if (idx < 0) begin
            ref_line.push_back(la);
            ref_data.push_back('0);
            ref_mask.push_back('0);
            ref_dirty.push_back(1'b0);
            idx = ref_line.size() - 1;
            lines_pushed++;
        end
        if (r.we) begin
            d = ref_data[idx];
            m = ref_mask[idx];
            base = 4 * int'(r.addr[3:2]);
            for (int k = 0; k < 4; k++) begin
                if (r.be[k]) begin
                    d[(base+k)*8 +: 8] = r.data[k*8 +: 8];
                    m[base+k] = 1'b1;
                end
            end
            ref_data[idx] = d;
            ref_mask[idx] = m;
            ref_dirty[idx] = 1'b1;
        end
    endtask

    task automatic check_fill(input logic done_was);
        cacheline_t mem;
        cacheline_t d;
        line_mask_t m;
        cacheline_t exp_data;
        addr_t exp_addr;
        if (o_fill_en !== done_was)
            report_failure("fill strobe did not come one cycle after CCU done");
        if (o_fill_en === 1'b1) begin
            if (ref_line.size() == 0) begin
                report_failure("fill arrived with no line left in the reference queue");
            end else begin
                mem = ccu_line(ref_line[0]);
                d = ref_data[0];
                m = ref_mask[0];
                for (int b = 0; b < `DC_LINE_SIZE; b++)
                    exp_data[b*8 +: 8] = m[b] ? d[b*8 +: 8] : mem[b*8 +: 8];
                exp_addr = {ref_line[0], {`DC_OFFSET_WIDTH{1'b0}}};
                if (o_fill_addr !== exp_addr)
                    report_mismatch("o_fill_addr", exp_addr, o_fill_addr);
                if (o_fill_addr !== ccu_req_addr)
                    report_mismatch("o_fill_addr", ccu_req_addr, o_fill_addr);
                if (o_fill_tag !== fill_tag)
                    report_mismatch("o_fill_tag", fill_tag, o_fill_tag);
                if (o_fill_dirty !== ref_dirty[0])
                    report_mismatch("o_fill_dirty", ref_dirty[0], o_fill_dirty);
                if (o_fill_data !== exp_data)
                    report_mismatch("o_fill_data", exp_data, o_fill_data);
                fill_tag++;
                void'(ref_line.pop_front());
                void'(ref_data.pop_front());
                void'(ref_mask.pop_front());
                void'(ref_dirty.pop_front());
            end
        end
    endtask

    // CCU answers each request after 1 to 4 cycles
    task automatic run_ccu();
        addr_t exp_addr;
        i_ccu_done = 1'b0;
        if (ccu_wait > 0) begin
            ccu_wait--;
            if (ccu_wait == 0) begin
                if (o_ccu_en !== 1'b1 || o_ccu_addr !== ccu_req_addr)
                    report_failure("CCU request dropped or changed before done");
                i_ccu_done = 1'b1;
                i_ccu_data = ccu_line(ccu_req_addr[`ADDR_WIDTH-1:`DC_OFFSET_WIDTH]);
            end
        end else if (o_ccu_en === 1'b1 && !ccu_hold) begin
            if (ref_line.size() == 0) begin
                report_failure("CCU request with no line in the reference queue");
            end else begin
                exp_addr = {ref_line[0], {`DC_OFFSET_WIDTH{1'b0}}};
                if (o_ccu_addr !== exp_addr)
                    report_mismatch("o_ccu_addr", exp_addr, o_ccu_addr);
            end
            ccu_req_addr = o_ccu_addr;
            ccu_reqs++;
            rng = xorshift32(rng);
            ccu_wait = 1 + int'(rng[1:0]);
        end
    endtask

    task automatic tick();
        logic done_was;
        @(negedge clk);
        done_was = i_ccu_done;
        check_fill(done_was);
        run_ccu();
    endtask

    task automatic apply_row(input row_t r);
        i_req_en = 1'b1;
        i_req_we = r.we;
        i_req_addr = r.addr;
        i_req_wr_data = r.data;
        i_req_byte_select = r.be;
        if (!r.replay)
            enqueue_ref(r);
        tick();
        i_req_en = 1'b0;
        if (o_req_replay !== r.replay)
            report_mismatch("o_req_replay", r.replay, o_req_replay);
        repeat (int'(r.gap)) tick();
    endtask

    task automatic begin_test(input int t);
        err_start = errors;
        reqs_start = ccu_reqs;
        lines_start = lines_pushed;
        ccu_hold = test_hold[t];
    endtask

    task automatic report_test(input string name);
        if (errors == err_start) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: fail with %0d errors", name, errors - err_start);
        end
    endtask

    // Release a held CCU, drain the queue and check the request count
    task automatic end_test(input int t);
        logic exp_full;
        if (test_hold[t]) begin
            exp_full = (ref_line.size() == `MHQ_DEPTH);
            if (o_mhq_full !== exp_full)
                report_mismatch("o_mhq_full", exp_full, o_mhq_full);
            ccu_hold = 1'b0;
        end
        while (ref_line.size() != 0)
            tick();
        repeat (3) tick();
        if (o_ccu_en !== 1'b0)
            report_mismatch("o_ccu_en", 0, o_ccu_en);
        if (o_mhq_full !== 1'b0)
            report_mismatch("o_mhq_full", 0, o_mhq_full);
        if (ccu_reqs - reqs_start != lines_pushed - lines_start)
            report_failure("CCU request count differs from the number of queued lines");
        report_test(test_names[t]);
    endtask

    initial begin
        int t;
        clk = 1'b0;
        n_rst = 1'b0;
        i_req_en = 1'b0;
        i_req_we = 1'b0;
        i_req_addr = '0;
        i_req_wr_data = '0;
        i_req_byte_select = '0;
        i_ccu_done = 1'b0;
        i_ccu_data = '0;
        rng = 32'h71a3_a49e;
        ccu_hold = 1'b0;
        ccu_wait = 0;
        ccu_req_addr = '0;
        fill_tag = '0;
        errors = 0;
        pass_count = 0;
        fail_count = 0;
        ccu_reqs = 0;
        lines_pushed = 0;
        cycles = 0;
        load_table();
        cycle_limit = rows.size() * 40 + 200;

        repeat (3) @(negedge clk);
        n_rst = 1'b1;

        // Idle outputs after reset
        err_start = errors;
        tick();
        if (o_fill_en !== 1'b0)
            report_mismatch("o_fill_en", 0, o_fill_en);
        if (o_ccu_en !== 1'b0)
            report_mismatch("o_ccu_en", 0, o_ccu_en);
        if (o_mhq_full !== 1'b0)
            report_mismatch("o_mhq_full", 0, o_mhq_full);
        if (o_req_replay !== 1'b0)
            report_mismatch("o_req_replay", 0, o_req_replay);
        report_test("reset");

        t = 0;
        begin_test(t);
        foreach (rows[r]) begin
            apply_row(rows[r]);
            if (rows[r].last) begin
                end_test(t);
                t++;
                if (t < 5)
                    begin_test(t);
            end
        end

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
+incdir+tb
source/cache_types_pkg.sv
source/mhq_types_pkg.sv
source/mhq_lu.sv
source/mhq_ex.sv
source/mhq_top.sv
tb/mhq_tb.sv
